//--- design/dbg_inject.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_inject
   import ib_pkg::*;
   import dbg_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               dbg_cmd_valid,
   input  logic               dbg_cmd_write,
   input  logic [1:0]         dbg_cmd_type,
   input  dbg_addr_u          dbg_cmd_addr,
   output logic               debug_valid,
   output logic [INSTR_W-1:0] debug_instr,
   output logic               dec_debug_wdata_rs1_d,
   output logic               dec_debug_fence_d
);

   logic rd_gpr;
   logic wr_gpr;
   logic rd_csr;
   logic wr_csr;
   logic fence_in;

   // memory accesses go elsewhere
   assign debug_valid = dbg_cmd_valid & (dbg_cmd_type != DBG_TYPE_MEM);

   assign rd_gpr = debug_valid & ~dbg_cmd_write & (dbg_cmd_type == DBG_TYPE_GPR);
   assign wr_gpr = debug_valid &  dbg_cmd_write & (dbg_cmd_type == DBG_TYPE_GPR);
   assign rd_csr = debug_valid & ~dbg_cmd_write & (dbg_cmd_type == DBG_TYPE_CSR);
   assign wr_csr = debug_valid &  dbg_cmd_write & (dbg_cmd_type == DBG_TYPE_CSR);

   always_comb begin
      debug_instr = '0;
      if (rd_gpr) begin
         debug_instr = DBG_GPR_RD_INSTR | {12'b0, dbg_cmd_addr.gpr.idx, 15'b0}; // rs1
      end
      if (wr_gpr) begin
         debug_instr = DBG_GPR_WR_INSTR | {20'b0, dbg_cmd_addr.gpr.idx, 7'b0};  // rd
      end
      if (rd_csr) begin
         debug_instr = DBG_CSR_RD_INSTR | {dbg_cmd_addr.csr, 20'b0};
      end
      if (wr_csr) begin
         debug_instr = DBG_CSR_WR_INSTR | {dbg_cmd_addr.csr, 20'b0};
      end
   end

   assign fence_in = wr_csr & (dbg_cmd_addr.csr == DBG_FENCE_CSR);

   // core is halted, so the injected instruction decodes in the next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_debug_wdata_rs1_d <= 1'b0;
         dec_debug_fence_d     <= 1'b0;
      end else begin
         dec_debug_wdata_rs1_d <= wr_gpr | wr_csr;
         dec_debug_fence_d     <= fence_in;
      end
   end

   // a fence always comes from a csr write
   a_fence_is_write : assert property (
      @(posedge clk) disable iff (reset)
      dec_debug_fence_d |-> dec_debug_wdata_rs1_d
   ) else $error("debug fence without write data");

endmodule

`default_nettype wire

//--- design/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

   // abstract command types from the debug module
   localparam logic [1:0] DBG_TYPE_GPR = 2'd0;
   localparam logic [1:0] DBG_TYPE_CSR = 2'd1;
   localparam logic [1:0] DBG_TYPE_MEM = 2'd2; // handled by the lsu, never buffered here

   // writing this csr from debug mode requests a fence
   localparam logic [11:0] DBG_FENCE_CSR = 12'h7c4;

   // fixed parts of the synthesized instructions
   // the register index or csr address is or'ed in afterwards

   // or x0, reg, x0 puts the register on rs1 (bits 19:15)
   localparam logic [31:0] DBG_GPR_RD_INSTR = 32'h0000_6033;

   // or reg, x0, x0 writes rs1 data into rd (bits 11:7)
   localparam logic [31:0] DBG_GPR_WR_INSTR = 32'h0000_6033;

   // csrrs x0, csr, x0 with the csr in bits 31:20
   localparam logic [31:0] DBG_CSR_RD_INSTR = 32'h0000_2073;

   // csrrw x0, csr, x0 with write data taken from rs1
   localparam logic [31:0] DBG_CSR_WR_INSTR = 32'h0000_1073;

   // low 12 bits of the command address
   // gpr commands only look at the 5-bit index
   typedef union packed {
      struct packed {
         logic [6:0] pad;
         logic [4:0] idx;
      } gpr;
      logic [11:0] csr;
   } dbg_addr_u;

endpackage

`default_nettype wire

//--- design/ib_ctl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ib_ctl_if
   import ib_pkg::*;
();

   ib_slot_t wr_i0;          // load slot k from fetch lane i0
   ib_slot_t wr_i1;          // load slot k from fetch lane i1, bit 0 stays low
   logic     sh_1_0;         // shift by one
   logic     sh_2_1;
   logic     sh_3_2;
   logic     sh_2_0;         // shift by two
   logic     sh_3_1;
   logic     ib0_from_debug; // ib0 instruction comes from the debug word

   modport ctl (
      output wr_i0, wr_i1,
      output sh_1_0, sh_2_1, sh_3_2,
      output sh_2_0, sh_3_1,
      output ib0_from_debug
   );

   modport array (
      input wr_i0, wr_i1,
      input sh_1_0, sh_2_1, sh_3_2,
      input sh_2_0, sh_3_1,
      input ib0_from_debug
   );

endinterface

`default_nettype wire

//--- design/ib_entry_array.sv
`timescale 1ns/10ps
`default_nettype none

module ib_entry_array
   import ib_pkg::*;
(
   input  logic               clk,
   input  ib_entry_t          ifu_i0_entry,
   input  ib_entry_t          ifu_i1_entry,
   input  logic [INSTR_W-1:0] debug_instr,
   ib_ctl_if.array            arr,
   output ib_entry_t          ib0_entry,
   output ib_entry_t          ib1_entry
);

   ib_entry_t slot_q [IB_DEPTH];
   ib_entry_t slot_d [IB_DEPTH];
   ib_slot_t  slot_en;
   ib_entry_t i0_to_ib0;  // i0 entry as seen by ib0

   // and-or leg of a one-hot mux
   function automatic ib_entry_t pick(input logic sel, input ib_entry_t ent);
      return sel ? ent : '0;
   endfunction

   always_comb begin
      i0_to_ib0 = ifu_i0_entry;
      if (arr.ib0_from_debug) begin
         i0_to_ib0.instr = debug_instr; // pc and fault bits still follow lane i0
      end
   end

   always_comb begin
      slot_d[3] = pick(arr.wr_i0[3], ifu_i0_entry) |
                  pick(arr.wr_i1[3], ifu_i1_entry);

      slot_d[2] = pick(arr.wr_i0[2], ifu_i0_entry) |
                  pick(arr.wr_i1[2], ifu_i1_entry) |
                  pick(arr.sh_3_2,   slot_q[3]);

      slot_d[1] = pick(arr.wr_i0[1], ifu_i0_entry) |
                  pick(arr.wr_i1[1], ifu_i1_entry) |
                  pick(arr.sh_2_1,   slot_q[2]) |
                  pick(arr.sh_3_1,   slot_q[3]);

      slot_d[0] = pick(arr.wr_i0[0], i0_to_ib0) |
                  pick(arr.sh_1_0,   slot_q[1]) |
                  pick(arr.sh_2_0,   slot_q[2]);
   end

   // a slot loads whenever any of its sources is selected
   assign slot_en[3] = arr.wr_i0[3] | arr.wr_i1[3];
   assign slot_en[2] = arr.wr_i0[2] | arr.wr_i1[2] | arr.sh_3_2;
   assign slot_en[1] = arr.wr_i0[1] | arr.wr_i1[1] | arr.sh_2_1 | arr.sh_3_1;
   assign slot_en[0] = arr.wr_i0[0] | arr.sh_1_0 | arr.sh_2_0;

   always_ff @(posedge clk) begin
      for (int k = 0; k < IB_DEPTH; k++) begin
         if (slot_en[k]) begin
            slot_q[k] <= slot_d[k];
         end
      end
   end

   assign ib0_entry = slot_q[0];
   assign ib1_entry = slot_q[1];

   // the and-or muxes rely on the control block keeping valids packed low
   a_sel_ib0 : assert property (
      @(posedge clk) $onehot0({arr.wr_i0[0], arr.sh_1_0, arr.sh_2_0})
   ) else $error("ib0 has more than one source");

   a_sel_ib1 : assert property (
      @(posedge clk) $onehot0({arr.wr_i0[1], arr.wr_i1[1], arr.sh_2_1, arr.sh_3_1})
   ) else $error("ib1 has more than one source");

   a_sel_ib2 : assert property (
      @(posedge clk) $onehot0({arr.wr_i0[2], arr.wr_i1[2], arr.sh_3_2})
   ) else $error("ib2 has more than one source");

   a_sel_ib3 : assert property (
      @(posedge clk) $onehot0({arr.wr_i0[3], arr.wr_i1[3]})
   ) else $error("ib3 has more than one source");

endmodule

`default_nettype wire

//--- design/ib_pkg.sv
`default_nettype none

package ib_pkg;

   localparam int IB_DEPTH = 4;  // slots ib0..ib3
   localparam int INSTR_W  = 32;
   localparam int PC_W     = 31; // pc[31:1], bit 0 is implied

   // one bit per slot, used for valids and for slot write selects
   typedef logic [IB_DEPTH-1:0] ib_slot_t;

   // fault bits carried with every buffered instruction
   typedef struct packed {
      logic icaf_second; // access fault on the upper half of a 4B instruction
      logic dbecc;       // double-bit ecc error
      logic sbecc;       // single-bit ecc error
      logic perr;        // parity error
      logic icaf;        // access fault
   } ib_fault_t;

   // one buffer slot
   // fault and pc sit above the instruction word, 69 bits in all
   typedef struct packed {
      ib_fault_t             fault;
      logic [PC_W-1:0]       pc;
      logic                  pc4;   // 4B instruction, else 2B
      logic [INSTR_W-1:0]    instr;
   } ib_entry_t;

endpackage

`default_nettype wire

//--- design/ib_top.sv
`timescale 1ns/10ps
`default_nettype none

module ib_top
   import ib_pkg::*;
   import dbg_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               exu_flush_final,

   input  logic               ifu_i0_valid,
   input  logic [INSTR_W-1:0] ifu_i0_instr,
   input  logic [PC_W:1]      ifu_i0_pc,
   input  logic               ifu_i0_pc4,
   input  logic               ifu_i0_icaf,
   input  logic               ifu_i0_icaf_second,
   input  logic               ifu_i0_perr,
   input  logic               ifu_i0_sbecc,
   input  logic               ifu_i0_dbecc,

   input  logic               ifu_i1_valid,
   input  logic [INSTR_W-1:0] ifu_i1_instr,
   input  logic [PC_W:1]      ifu_i1_pc,
   input  logic               ifu_i1_pc4,
   input  logic               ifu_i1_icaf,
   input  logic               ifu_i1_icaf_second,
   input  logic               ifu_i1_perr,
   input  logic               ifu_i1_sbecc,
   input  logic               ifu_i1_dbecc,

   input  logic               dec_i0_decode_d,
   input  logic               dec_i1_decode_d,

   input  logic               dbg_cmd_valid,
   input  logic               dbg_cmd_write,
   input  logic [1:0]         dbg_cmd_type,
   input  logic [31:0]        dbg_cmd_addr,

   output logic               dec_ib0_valid_d,
   output logic               dec_ib1_valid_d,
   output logic               dec_ib2_valid_d,
   output logic               dec_ib3_valid_d,

   output logic [INSTR_W-1:0] dec_i0_instr_d,
   output logic [PC_W:1]      dec_i0_pc_d,
   output logic               dec_i0_pc4_d,
   output logic               dec_i0_icaf_d,
   output logic               dec_i0_icaf_second_d,
   output logic               dec_i0_perr_d,
   output logic               dec_i0_sbecc_d,
   output logic               dec_i0_dbecc_d,

   output logic [INSTR_W-1:0] dec_i1_instr_d,
   output logic [PC_W:1]      dec_i1_pc_d,
   output logic               dec_i1_pc4_d,
   output logic               dec_i1_icaf_d,
   output logic               dec_i1_perr_d,
   output logic               dec_i1_sbecc_d,
   output logic               dec_i1_dbecc_d,

   output logic               dec_debug_wdata_rs1_d,
   output logic               dec_debug_fence_d
);

   ib_entry_t          i0_entry;
   ib_entry_t          i1_entry;
   ib_entry_t          ib0_entry;
   ib_entry_t          ib1_entry;
   ib_slot_t           ib_valid;
   dbg_addr_u          cmd_addr_lo;
   logic               debug_valid;
   logic [INSTR_W-1:0] debug_instr;

   ib_ctl_if u_ctl_if ();

   assign i0_entry = '{fault: '{icaf_second: ifu_i0_icaf_second, dbecc: ifu_i0_dbecc,
                                sbecc: ifu_i0_sbecc, perr: ifu_i0_perr, icaf: ifu_i0_icaf},
                       pc: ifu_i0_pc, pc4: ifu_i0_pc4, instr: ifu_i0_instr};

   assign i1_entry = '{fault: '{icaf_second: ifu_i1_icaf_second, dbecc: ifu_i1_dbecc,
                                sbecc: ifu_i1_sbecc, perr: ifu_i1_perr, icaf: ifu_i1_icaf},
                       pc: ifu_i1_pc, pc4: ifu_i1_pc4, instr: ifu_i1_instr};

   assign cmd_addr_lo = dbg_cmd_addr[11:0]; // register index or csr address

   ib_write_ctl u_write_ctl (
      .clk             (clk),
      .reset           (reset),
      .exu_flush_final (exu_flush_final),
      .ifu_i0_valid    (ifu_i0_valid),
      .ifu_i1_valid    (ifu_i1_valid),
      .dec_i0_decode_d (dec_i0_decode_d),
      .dec_i1_decode_d (dec_i1_decode_d),
      .debug_valid     (debug_valid),
      .ib_valid        (ib_valid),
      .ctl             (u_ctl_if.ctl)
   );

   ib_entry_array u_entry_array (
      .clk          (clk),
      .ifu_i0_entry (i0_entry),
      .ifu_i1_entry (i1_entry),
      .debug_instr  (debug_instr),
      .arr          (u_ctl_if.array),
      .ib0_entry    (ib0_entry),
      .ib1_entry    (ib1_entry)
   );

   dbg_inject u_dbg_inject (
      .clk                   (clk),
      .reset                 (reset),
      .dbg_cmd_valid         (dbg_cmd_valid),
      .dbg_cmd_write         (dbg_cmd_write),
      .dbg_cmd_type          (dbg_cmd_type),
      .dbg_cmd_addr          (cmd_addr_lo),
      .debug_valid           (debug_valid),
      .debug_instr           (debug_instr),
      .dec_debug_wdata_rs1_d (dec_debug_wdata_rs1_d),
      .dec_debug_fence_d     (dec_debug_fence_d)
   );

   assign {dec_ib3_valid_d, dec_ib2_valid_d, dec_ib1_valid_d, dec_ib0_valid_d} = ib_valid;

   assign dec_i0_instr_d       = ib0_entry.instr;
   assign dec_i0_pc_d          = ib0_entry.pc;
   assign dec_i0_pc4_d         = ib0_entry.pc4;
   assign dec_i0_icaf_d        = ib0_entry.fault.icaf;
   assign dec_i0_icaf_second_d = ib0_entry.fault.icaf_second; // faults only decode as i0
   assign dec_i0_perr_d        = ib0_entry.fault.perr;
   assign dec_i0_sbecc_d       = ib0_entry.fault.sbecc;
   assign dec_i0_dbecc_d       = ib0_entry.fault.dbecc;

   assign dec_i1_instr_d       = ib1_entry.instr;
   assign dec_i1_pc_d          = ib1_entry.pc;
   assign dec_i1_pc4_d         = ib1_entry.pc4;
   assign dec_i1_icaf_d        = ib1_entry.fault.icaf;
   assign dec_i1_perr_d        = ib1_entry.fault.perr;
   assign dec_i1_sbecc_d       = ib1_entry.fault.sbecc;
   assign dec_i1_dbecc_d       = ib1_entry.fault.dbecc;

endmodule

`default_nettype wire

//--- design/ib_write_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module ib_write_ctl
   import ib_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     exu_flush_final,
   input  logic     ifu_i0_valid,
   input  logic     ifu_i1_valid,
   input  logic     dec_i0_decode_d,
   input  logic     dec_i1_decode_d,
   input  logic     debug_valid,
   output ib_slot_t ib_valid,
   ib_ctl_if.ctl    ctl
);

   logic     flush_q;    // flush seen last edge
   logic     shift1;
   logic     shift2;
   logic     i0_ok;
   logic     i1_ok;
   ib_slot_t shift_val;  // valids after this cycle's decode shift
   ib_slot_t wr_i0;
   ib_slot_t wr_i1;
   ib_slot_t valid_next;

   assign shift1 = dec_i0_decode_d & ~dec_i1_decode_d;
   assign shift2 = dec_i0_decode_d &  dec_i1_decode_d;

   // room is judged on the current valids, before the shift
   assign i0_ok = ifu_i0_valid & ~ib_valid[3] & ~flush_q;
   assign i1_ok = ifu_i1_valid & ~ib_valid[2] & ~flush_q;

   assign shift_val = shift2 ? {2'b00, ib_valid[3:2]} :
                      shift1 ? {1'b0,  ib_valid[3:1]} :
                               ib_valid;

   // i0 lands in the first free slot, i1 right behind it
   assign wr_i0[0] = ~shift_val[0] & (i0_ok | debug_valid); // debug needs no room check
   assign wr_i0[1] =  shift_val[0] & ~shift_val[1] & i0_ok;
   assign wr_i0[2] =  shift_val[1] & ~shift_val[2] & i0_ok;
   assign wr_i0[3] =  shift_val[2] & ~shift_val[3] & i0_ok;

   assign wr_i1[0] = 1'b0;                                  // i1 never reaches ib0
   assign wr_i1[1] = ~shift_val[0] & i1_ok;
   assign wr_i1[2] =  shift_val[0] & ~shift_val[1] & i1_ok;
   assign wr_i1[3] =  shift_val[1] & ~shift_val[2] & i1_ok;

   assign ctl.wr_i0 = wr_i0;
   assign ctl.wr_i1 = wr_i1;

   // moves only where the source slot holds something
   assign ctl.sh_1_0 = shift1 & ib_valid[1];
   assign ctl.sh_2_1 = shift1 & ib_valid[2];
   assign ctl.sh_3_2 = shift1 & ib_valid[3];
   assign ctl.sh_2_0 = shift2 & ib_valid[2];
   assign ctl.sh_3_1 = shift2 & ib_valid[3];

   assign ctl.ib0_from_debug = debug_valid;

   assign valid_next = (shift_val | wr_i0 | wr_i1) & ~{IB_DEPTH{flush_q}};

   always_ff @(posedge clk) begin
      if (reset) begin
         flush_q  <= 1'b0;
         ib_valid <= '0;
      end else begin
         flush_q  <= exu_flush_final;
         ib_valid <= valid_next;
      end
   end

   // a new instruction never lands on top of one that survived the shift
   a_no_overwrite : assert property (
      @(posedge clk) disable iff (reset)
      ((wr_i0 | wr_i1) & shift_val) == '0
   ) else $error("write select hits an occupied slot");

   // decode retires in order, i1 only together with i0
   a_decode_order : assert property (
      @(posedge clk) disable iff (reset)
      dec_i1_decode_d |-> dec_i0_decode_d
   ) else $error("i1 decoded without i0");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_ib_top -f tb.f -o tb_ib_top_sim
./obj_dir/tb_ib_top_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation ok"

//--- tb.f
design/ib_pkg.sv
design/dbg_pkg.sv
design/ib_ctl_if.sv
design/ib_write_ctl.sv
design/ib_entry_array.sv
design/dbg_inject.sv
design/ib_top.sv
tb/tb_ib_top.sv

//--- tb/tb_ib_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ib_top
   import ib_pkg::*;
   import dbg_pkg::*;
();

   // everything the testbench drives into the DUT in one cycle
   typedef struct packed {
      logic        flush;
      logic        i0_valid;
      ib_entry_t   i0;
      logic        i1_valid;
      ib_entry_t   i1;
      logic        dec0;
      logic        dec1;
      logic        cmd_valid;
      logic        cmd_write;
      logic [1:0]  cmd_type;
      logic [31:0] cmd_addr;
   } stim_t;

   // reference state of the buffer
   typedef struct packed {
      ib_entry_t [IB_DEPTH-1:0] ent;
      ib_slot_t                 valid;
      logic                     flush_q;
      logic                     wdata_rs1;
      logic                     fence;
   } model_t;

   logic      clk;
   logic      reset;
   stim_t     stim;
   model_t    mdl;
   string     test_name;

   ib_slot_t  dut_valid;
   ib_entry_t dut_ib0;
   ib_entry_t dut_ib1;
   logic      dut_wdata_rs1;
   logic      dut_fence;

   assign dut_ib1.fault.icaf_second = 1'b0; // slot 1 has no icaf_second output

   ib_top u_ib_top (
      .clk                   (clk),
      .reset                 (reset),
      .exu_flush_final       (stim.flush),
      .ifu_i0_valid          (stim.i0_valid),
      .ifu_i0_instr          (stim.i0.instr),
      .ifu_i0_pc             (stim.i0.pc),
      .ifu_i0_pc4            (stim.i0.pc4),
      .ifu_i0_icaf           (stim.i0.fault.icaf),
      .ifu_i0_icaf_second    (stim.i0.fault.icaf_second),
      .ifu_i0_perr           (stim.i0.fault.perr),
      .ifu_i0_sbecc          (stim.i0.fault.sbecc),
      .ifu_i0_dbecc          (stim.i0.fault.dbecc),
      .ifu_i1_valid          (stim.i1_valid),
      .ifu_i1_instr          (stim.i1.instr),
      .ifu_i1_pc             (stim.i1.pc),
      .ifu_i1_pc4            (stim.i1.pc4),
      .ifu_i1_icaf           (stim.i1.fault.icaf),
      .ifu_i1_icaf_second    (stim.i1.fault.icaf_second),
      .ifu_i1_perr           (stim.i1.fault.perr),
      .ifu_i1_sbecc          (stim.i1.fault.sbecc),
      .ifu_i1_dbecc          (stim.i1.fault.dbecc),
      .dec_i0_decode_d       (stim.dec0),
      .dec_i1_decode_d       (stim.dec1),
      .dbg_cmd_valid         (stim.cmd_valid),
      .dbg_cmd_write         (stim.cmd_write),
      .dbg_cmd_type          (stim.cmd_type),
      .dbg_cmd_addr          (stim.cmd_addr),
      .dec_ib0_valid_d       (dut_valid[0]),
      .dec_ib1_valid_d       (dut_valid[1]),
      .dec_ib2_valid_d       (dut_valid[2]),
      .dec_ib3_valid_d       (dut_valid[3]),
      .dec_i0_instr_d        (dut_ib0.instr),
      .dec_i0_pc_d           (dut_ib0.pc),
      .dec_i0_pc4_d          (dut_ib0.pc4),
      .dec_i0_icaf_d         (dut_ib0.fault.icaf),
      .dec_i0_icaf_second_d  (dut_ib0.fault.icaf_second),
      .dec_i0_perr_d         (dut_ib0.fault.perr),
      .dec_i0_sbecc_d        (dut_ib0.fault.sbecc),
      .dec_i0_dbecc_d        (dut_ib0.fault.dbecc),
      .dec_i1_instr_d        (dut_ib1.instr),
      .dec_i1_pc_d           (dut_ib1.pc),
      .dec_i1_pc4_d          (dut_ib1.pc4),
      .dec_i1_icaf_d         (dut_ib1.fault.icaf),
      .dec_i1_perr_d         (dut_ib1.fault.perr),
      .dec_i1_sbecc_d        (dut_ib1.fault.sbecc),
      .dec_i1_dbecc_d        (dut_ib1.fault.dbecc),
      .dec_debug_wdata_rs1_d (dut_wdata_rs1),
      .dec_debug_fence_d     (dut_fence)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // riscv encodings of the injected instructions
   function automatic logic [31:0] dbg_ref_word(input logic wr, input logic [1:0] typ,
                                                input logic [11:0] addr);
      logic [31:0] w;
      w = '0;
      if (typ == DBG_TYPE_GPR && !wr) begin
         w = {7'b0, 5'd0, addr[4:0], 3'b110, 5'd0, 7'b0110011};  // or x0, reg, x0
      end else if (typ == DBG_TYPE_GPR) begin
         w = {7'b0, 5'd0, 5'd0, 3'b110, addr[4:0], 7'b0110011};  // or reg, x0, x0
      end else if (typ == DBG_TYPE_CSR && !wr) begin
         w = {addr, 5'd0, 3'b010, 5'd0, 7'b1110011};             // csrrs x0, csr, x0
      end else if (typ == DBG_TYPE_CSR) begin
         w = {addr, 5'd0, 3'b001, 5'd0, 7'b1110011};             // csrrw x0, csr, x0
      end
      return w;
   endfunction

   // one clock edge of the buffer
   function automatic model_t ib_ref_step(input model_t m, input stim_t s);
      model_t    n;
      int        sh;
      int        pos;
      logic      dbg;
      logic      is_reg;
      logic      i0_ok;
      logic      i1_ok;
      logic      put0;
      ib_entry_t e0;
      n       = m;
      n.valid = '0;
      sh      = s.dec0 ? (s.dec1 ? 2 : 1) : 0;
      pos     = 0;
      for (int k = 0; k < IB_DEPTH; k++) begin
         for (int j = 0; j < IB_DEPTH; j++) begin
            if (j == k + sh) begin
               n.ent[k]   = m.ent[j];
               n.valid[k] = m.valid[j];
            end
         end
         if (n.valid[k]) pos = k + 1;  // first free slot after the shift
      end
      is_reg = (s.cmd_type != DBG_TYPE_MEM);
      dbg    = s.cmd_valid && is_reg;
      i0_ok  = s.i0_valid && !m.valid[3] && !m.flush_q;  // room before the shift
      i1_ok  = s.i1_valid && !m.valid[2] && !m.flush_q;
      put0   = i0_ok || (dbg && pos == 0);
      e0     = s.i0;
      if (dbg && pos == 0) begin
         e0.instr = dbg_ref_word(s.cmd_write, s.cmd_type, s.cmd_addr[11:0]);
      end
      for (int k = 0; k < IB_DEPTH; k++) begin
         if (put0 && k == pos) begin
            n.ent[k]   = e0;
            n.valid[k] = 1'b1;
         end
         if (i1_ok && k == pos + 1) begin
            n.ent[k]   = s.i1;
            n.valid[k] = 1'b1;
         end
      end
      if (m.flush_q) n.valid = '0;
      n.flush_q   = s.flush;
      n.wdata_rs1 = dbg && s.cmd_write;
      n.fence     = dbg && s.cmd_write && (s.cmd_type == DBG_TYPE_CSR) &&
                    (s.cmd_addr[11:0] == 12'h7c4);
      return n;
   endfunction

   function automatic ib_entry_t ib1_view(input ib_entry_t e);
      ib_entry_t v;
      v                   = e;
      v.fault.icaf_second = 1'b0;
      return v;
   endfunction

   function automatic ib_entry_t rand_entry();
      ib_entry_t e;
      e.instr = $urandom;
      e.pc    = PC_W'($urandom);
      e.pc4   = 1'($urandom);
      e.fault = ib_fault_t'(5'($urandom));
      return e;
   endfunction

   task automatic abort_run();
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_valid(input string what, input ib_slot_t exp, input ib_slot_t act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_entry(input string what, input ib_entry_t exp, input ib_entry_t act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
         abort_run();
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         mdl = '0;
      end else begin
         mdl = ib_ref_step(mdl, stim);
      end
   end

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         check_valid("slot valids", mdl.valid, dut_valid);
         if (mdl.valid[0]) check_entry("ib0 entry", mdl.ent[0], dut_ib0);
         if (mdl.valid[1]) check_entry("ib1 entry", ib1_view(mdl.ent[1]), dut_ib1);
         check_flag("debug wdata_rs1", mdl.wdata_rs1, dut_wdata_rs1);
         check_flag("debug fence", mdl.fence, dut_fence);
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic idle();
      stim.flush     = 1'b0;
      stim.i0_valid  = 1'b0;
      stim.i1_valid  = 1'b0;
      stim.dec0      = 1'b0;
      stim.dec1      = 1'b0;
      stim.cmd_valid = 1'b0;
   endtask

   task automatic fetch_pair(input ib_entry_t a, input ib_entry_t b);
      idle();
      stim.i0_valid = 1'b1;
      stim.i1_valid = 1'b1;
      stim.i0       = a;
      stim.i1       = b;
      tick();
      idle();
   endtask

   // decode whatever is buffered until all slots are empty
   task automatic drain_buffer();
      int n;
      n = 0;
      idle();
      while (dut_valid !== '0) begin
         if (n == 8) begin
            $display("timeout in %s: buffer did not drain, valids %b", test_name, dut_valid);
            abort_run();
         end
         stim.dec0 = dut_valid[0];
         stim.dec1 = dut_valid[0] & dut_valid[1];
         tick();
         n++;
      end
      idle();
   endtask

   task automatic fill_test();
      ib_entry_t e [6];
      test_name = "fill";
      for (int k = 0; k < 6; k++) e[k] = rand_entry();
      fetch_pair(e[0], e[1]);
      fetch_pair(e[2], e[3]);
      check_valid("full after two fetches", 4'b1111, dut_valid);
      fetch_pair(e[4], e[5]);  // no room left
      check_valid("still full", 4'b1111, dut_valid);
      check_entry("ib0 kept", e[0], dut_ib0);
      check_entry("ib1 kept", ib1_view(e[1]), dut_ib1);
   endtask

   task automatic shift_test();
      ib_entry_t e [8];
      test_name = "shift";
      for (int k = 0; k < 8; k++) e[k] = rand_entry();
      drain_buffer();
      fetch_pair(e[0], e[1]);
      fetch_pair(e[2], e[3]);
      stim.dec0 = 1'b1;
      tick();
      idle();
      check_valid("after shift by one", 4'b0111, dut_valid);
      check_entry("ib0 after shift by one", e[1], dut_ib0);
      check_entry("ib1 after shift by one", ib1_view(e[2]), dut_ib1);
      stim.dec0 = 1'b1;
      stim.dec1 = 1'b1;
      tick();
      idle();
      check_valid("after shift by two", 4'b0001, dut_valid);
      check_entry("ib0 after shift by two", e[3], dut_ib0);
      fetch_pair(e[4], e[5]);
      check_valid("refill", 4'b0111, dut_valid);
      check_entry("ib1 after refill", ib1_view(e[4]), dut_ib1);
      // ib2 is full so only i0 fits, right behind the survivor
      stim.dec0     = 1'b1;
      stim.dec1     = 1'b1;
      stim.i0_valid = 1'b1;
      stim.i1_valid = 1'b1;
      stim.i0       = e[6];
      stim.i1       = e[7];
      tick();
      idle();
      check_valid("decode two while fetching", 4'b0011, dut_valid);
      check_entry("ib0 survivor", e[5], dut_ib0);
      check_entry("ib1 new entry", ib1_view(e[6]), dut_ib1);
   endtask

   task automatic flush_test();
      test_name = "flush";
      drain_buffer();
      fetch_pair(rand_entry(), rand_entry());
      stim.flush = 1'b1;
      tick();
      stim.flush = 1'b0;
      check_valid("one edge after flush", 4'b0011, dut_valid);
      stim.i0_valid = 1'b1;  // must be blocked by the registered flush
      stim.i1_valid = 1'b1;
      stim.i0       = rand_entry();
      stim.i1       = rand_entry();
      tick();
      idle();
      check_valid("two edges after flush", 4'b0000, dut_valid);
   endtask

   task automatic debug_cmd(input logic wr, input logic [1:0] typ, input logic [11:0] addr);
      ib_entry_t exp;
      logic      is_reg;
      drain_buffer();
      is_reg         = (typ != DBG_TYPE_MEM);
      stim.cmd_valid = 1'b1;
      stim.cmd_write = wr;
      stim.cmd_type  = typ;
      stim.cmd_addr  = {20'($urandom), addr};  // upper bits are ignored
      exp            = stim.i0;
      exp.instr      = dbg_ref_word(wr, typ, addr);
      tick();
      idle();
      if (is_reg) begin
         check_valid("debug valids", 4'b0001, dut_valid);
         check_entry("debug word", exp, dut_ib0);
      end else begin
         check_valid("memory command valids", 4'b0000, dut_valid);
      end
      check_flag("wdata_rs1", wr & is_reg, dut_wdata_rs1);
      check_flag("fence", wr & (typ == DBG_TYPE_CSR) & (addr == 12'h7c4), dut_fence);
      drain_buffer();
   endtask

   task automatic debug_test();
      test_name = "debug";
      debug_cmd(1'b0, DBG_TYPE_GPR, 12'($urandom));
      debug_cmd(1'b1, DBG_TYPE_GPR, 12'($urandom));
      debug_cmd(1'b0, DBG_TYPE_CSR, 12'h300);
      debug_cmd(1'b1, DBG_TYPE_CSR, 12'h341);
      debug_cmd(1'b1, DBG_TYPE_MEM, 12'h010);
      debug_cmd(1'b0, DBG_TYPE_MEM, 12'h7c4);
      test_name = "fence";
      debug_cmd(1'b1, DBG_TYPE_CSR, 12'h7c4);
      debug_cmd(1'b1, DBG_TYPE_CSR, 12'h7c5);
      debug_cmd(1'b0, DBG_TYPE_CSR, 12'h7c4);  // a read is no fence
   endtask

   task automatic random_test();
      test_name = "random";
      for (int c = 0; c < 3000; c++) begin
         stim.flush    = ($urandom % 60) == 0;
         stim.i0_valid = ($urandom % 4) != 0;
         stim.i1_valid = stim.i0_valid & (($urandom % 2) == 1);
         stim.i0       = rand_entry();
         stim.i1       = rand_entry();
         stim.dec0     = dut_valid[0] & (($urandom % 3) != 0);  // decode only what is there
         stim.dec1     = stim.dec0 & dut_valid[1] & (($urandom % 2) == 0);
         tick();
      end
      idle();
   endtask

   initial begin
      void'($urandom(37582));
      test_name = "reset";
      reset     = 1'b1;
      stim      = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      fill_test();
      shift_test();
      flush_test();
      debug_test();
      random_test();
      test_name = "final drain";
      drain_buffer();
      tick();
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire
